/* Makefile */
# Verilator build for the DAC output block and its testbench
TOP := tb_dac_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

obj_dir/V$(TOP): vlog.f common/*.sv dac/*.sv verilog/*.sv sim/*.sv
	verilator --binary --timing -f vlog.f --top-module $(TOP) -o V$(TOP)

# pass only when the pass line shows up in the output
sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf obj_dir

/* common/dac_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DAC command codes, word layout, sequencer counts, packed structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package dac_pkg;

    localparam int num_dac_ch = 4;                   // LTC2601 chain length or LTC2604 channels
    localparam int dac_addr_w = $clog2(num_dac_ch);  // command memory address width

    // field widths of one 32-bit command word
    localparam int pad_w  = 8;
    localparam int cmd_w  = 4;
    localparam int ch_w   = 4;
    localparam int val_w  = 16;
    localparam int word_w = pad_w + cmd_w + ch_w + val_w;

    localparam logic [cmd_w-1:0] cmd_write_update = 4'h3;  // write and update dac
    localparam logic [cmd_w-1:0] cmd_nop          = 4'h7;  // no operation

    // shifter sequence counts
    localparam logic [8:0] seqn_init    = 9'h100;  // 256 counts to rollover
    localparam logic [8:0] seqn_done    = 9'h1ff;  // last count of a transfer
    localparam logic [4:0] seqn_word    = 5'h1f;   // word boundary, every 64 counts
    localparam logic [4:0] seqn_flush   = 5'h0f;   // mid word, word already latched
    localparam logic [4:0] seqn_csel_on = 5'h07;   // csel low after 8 sclks (quad)

    typedef struct packed {
        logic [pad_w-1:0] pad;      // always zero
        logic [cmd_w-1:0] cmd;      // command nibble
        logic [ch_w-1:0]  ch_addr;  // LTC2604 channel, ignored by LTC2601
        logic [val_w-1:0] value;    // dac setpoint
    } dac_word_t;

    typedef struct packed {
        logic [num_dac_ch-1:0]            ch_mask;  // one bit per channel
        logic [num_dac_ch-1:0][val_w-1:0] value;    // setpoints, index = channel
    } dac_update_t;

    typedef struct packed {
        logic                  wr_en;
        logic [dac_addr_w-1:0] wr_addr;
        dac_word_t             wr_word;
    } mem_wr_t;

    function automatic dac_word_t make_word(input logic [cmd_w-1:0] cmd,
                                            input logic [dac_addr_w-1:0] ch,
                                            input logic [val_w-1:0] value);
        dac_word_t w;
        w.pad     = '0;
        w.cmd     = cmd;
        w.ch_addr = ch_w'(ch);    // zero extended channel index
        w.value   = value;
        return w;
    endfunction

    function automatic dac_word_t nop_word(input logic [dac_addr_w-1:0] ch);
        return make_word(cmd_nop, ch, '0);  // keeps channel, clears value
    endfunction

endpackage

/* dac/dac_cmd_mem.sv */
`timescale 1ns/1ns
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// four-entry DAC command word memory with flush to nop
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module dac_cmd_mem
    import dac_pkg::*;
(
    input  logic                  clkin,  // system clock
    input  logic                  rst,    // sync reset, active high
    input  mem_wr_t               wr,     // write port from update controller
    input  logic [dac_addr_w-1:0] addr,   // read address from shifter
    input  logic                  flush,  // clear entry at addr to nop
    output dac_word_t             word    // combinational read data
);

    dac_word_t mem [num_dac_ch];  // one command word per channel

    always_ff @(posedge clkin) begin
        for (int i = 0; i < num_dac_ch; i++) begin
            if (rst) begin
                mem[i] <= nop_word(dac_addr_w'(i));     // nop with own channel
            end else if (wr.wr_en && (wr.wr_addr == dac_addr_w'(i))) begin
                mem[i] <= wr.wr_word;                   // write beats flush
            end else if (flush && (addr == dac_addr_w'(i))) begin
                mem[i] <= nop_word(dac_addr_w'(i));     // sent once only
            end
        end
    end

    // shifter latches the word on the same edge that it moves addr on
    assign word = mem[addr];

endmodule

/* dac/dac_spi_shifter.sv */
`timescale 1ns/1ns
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// serial shifter, 4x LTC2601 chain or 1x LTC2604 quad
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module dac_spi_shifter
    import dac_pkg::*;
(
    input  logic                  clkin,        // system clock
    input  logic                  rst,          // sync reset, active high
    input  logic                  trig,         // starts a transfer, sampled in idle
    input  dac_word_t             word,         // command word read at addr
    output logic [dac_addr_w-1:0] addr,         // command memory read address
    output logic                  flush,        // turn entry at addr into nop
    input  logic                  is_quad_dac,  // 0 = 4x LTC2601, 1 = 1x LTC2604
    output logic                  sclk,         // serial clock, half the clkin rate
    output logic                  csel,         // frame select, active low
    output logic                  mosi,         // serial data, msb first
    output logic                  busy,         // transfer in progress
    output logic                  xfer_done     // final count of the transfer
);

    typedef enum logic {
        st_idle,
        st_loop
    } shift_state_t;

    shift_state_t      state;
    logic [8:0]        seqn;       // sequence counter, lsb is sclk
    logic [word_w-1:0] data;       // shift register, msb on mosi
    logic              word_edge;  // last count pair of a 32-bit word

    assign sclk = seqn[0];
    assign mosi = data[word_w-1];
    assign busy = ~csel;

    assign word_edge = (seqn[5:1] == seqn_word);
    // look ahead one word at the boundary so the next word is ready to latch
    assign addr = seqn[7:6] + {1'b0, word_edge};
    assign flush = (seqn[5:1] == seqn_flush);  // stays at 0x100 in idle, so never fires there

    assign xfer_done = (state == st_loop) && (seqn == seqn_done);

    always_ff @(posedge clkin) begin
        if (rst) begin
            state <= st_idle;
            seqn  <= seqn_init;
            csel  <= 1'b1;              // deselected
            data  <= '0;                // keeps mosi low
        end else begin
            case (state)
                st_idle: begin
                    seqn <= seqn_init;  // 256 counts once started
                    if (trig) begin
                        csel  <= is_quad_dac;  // 2601 chain selects at once
                        data  <= word;         // first word, addr is 0 here
                        state <= st_loop;
                    end else begin
                        csel <= 1'b1;
                        data <= '0;
                    end
                end

                st_loop: begin
                    seqn <= seqn + 9'd1;
                    if (sclk) begin     // falling sclk next, move data
                        data <= word_edge ? word : {data[word_w-2:0], 1'b0};
                        if (is_quad_dac && word_edge) begin
                            csel <= 1'b1;   // 2604 needs a new 24-bit frame per word
                        end
                        if (seqn[5:1] == seqn_csel_on) begin
                            csel <= 1'b0;   // pad bits gone, select for 24 bits
                        end
                    end
                    if (xfer_done) begin
                        csel  <= 1'b1;      // end of transfer
                        data  <= '0;
                        state <= st_idle;
                    end
                end

                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

/* sim/dac_spi_monitor.sv */
`timescale 1ns/1ns
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DAC receiver model, frame rebuild and framing checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module dac_spi_monitor
    import dac_pkg::*;
(
    input  logic                           clkin,        // system clock
    input  logic                           rst,          // sync reset, active high
    input  logic                           sclk,         // DAC serial clock
    input  logic                           csel,         // DAC chip select, active low
    input  logic                           mosi,         // DAC serial data
    input  logic                           quad,         // board mode, static in a transfer
    output logic                           frame_valid,  // one cycle per finished frame
    output logic [num_dac_ch*word_w-1:0]   frame_data,   // frame bits, last bit in lsb
    output int                             frame_cnt,    // frames finished so far
    output logic                           frame_err     // sticky framing error
);

    logic                         sclk_q;    // sclk at the previous sample
    logic                         csel_q;    // csel at the previous sample
    logic                         quad_q;    // mode taken at csel fall
    logic [num_dac_ch*word_w-1:0] shreg;     // receive shift register
    int                           nbits;     // bits in the current frame
    int                           pad_clks;  // rising sclks seen with csel high

    // sampled mid cycle, all bus signals settle on the rising clkin edge
    always @(negedge clkin) begin
        if (rst) begin
            sclk_q      <= 1'b0;
            csel_q      <= 1'b1;
            quad_q      <= 1'b0;
            shreg       <= '0;
            nbits       <= 0;
            pad_clks    <= 0;
            frame_valid <= 1'b0;
            frame_data  <= '0;
            frame_cnt   <= 0;
            frame_err   <= 1'b0;
        end else begin
            sclk_q      <= sclk;
            csel_q      <= csel;
            frame_valid <= 1'b0;
            if (csel_q && !csel) begin                      // frame start
                if (quad && pad_clks != pad_w) begin
                    $display("framing error: %0d pad clocks before a quad frame", pad_clks);
                    frame_err <= 1'b1;
                end
                quad_q   <= quad;
                shreg    <= '0;
                nbits    <= 0;
                pad_clks <= 0;
            end else if (!csel_q && csel) begin             // frame end
                if (nbits != (quad_q ? word_w - pad_w : num_dac_ch * word_w)) begin
                    $display("framing error: frame of %0d bits has the wrong length", nbits);
                    frame_err <= 1'b1;
                end
                frame_valid <= 1'b1;
                frame_data  <= shreg;
                frame_cnt   <= frame_cnt + 1;
                pad_clks    <= 0;
            end else if (sclk && !sclk_q) begin             // rising sclk
                if (!csel) begin
                    shreg <= {shreg[num_dac_ch*word_w-2:0], mosi};  // msb arrives first
                    nbits <= nbits + 1;
                end else begin
                    pad_clks <= pad_clks + 1;
                    if (!quad || pad_clks >= pad_w) begin   // only quad pad bits are legal
                        $display("framing error: sclk toggling while the bus is idle");
                        frame_err <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

/* sim/tb_dac_top.sv */
`timescale 1ns/1ns
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for dac_top, LFSR stimulus, frame model, checks, watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_dac_top
    import dac_pkg::*;
();

    typedef logic [num_dac_ch*word_w-1:0] frame_t;  // one 2601 chain frame

    localparam int phase_len      = 8;                // updates in each fixed-mode phase
    localparam int n_upd          = 40;               // updates over all phases
    localparam int max_gap        = 15;               // 4-bit random gap
    localparam int margin         = 64;               // latency, reset and drain slack
    localparam int timeout_cycles = n_upd * (256 + max_gap + margin);
    localparam int drain_cycles   = 300;              // longer than one transfer
    localparam int mode_2601      = 0;
    localparam int mode_quad      = 1;
    localparam int mode_mixed     = 2;                // random mode per update

    logic        clkin;
    logic        rst;
    logic        upd_valid;
    dac_update_t upd;
    logic        upd_ready;
    logic        is_quad_dac;
    logic        sclk;
    logic        csel;
    logic        mosi;
    logic        busy;

    logic        frame_valid;
    frame_t      frame_data;
    int          frame_cnt;
    logic        mon_err;

    logic [15:0] lfsr = 16'd73;   // random state
    frame_t      exp_q[$];        // expected frames, oldest first
    string       exp_name[$];     // phase that queued each frame

    dac_top uut (
        .clkin       (clkin),
        .rst         (rst),
        .upd_valid   (upd_valid),
        .upd         (upd),
        .upd_ready   (upd_ready),
        .is_quad_dac (is_quad_dac),
        .sclk        (sclk),
        .csel        (csel),
        .mosi        (mosi),
        .busy        (busy)
    );

    dac_spi_monitor mon (
        .clkin       (clkin),
        .rst         (rst),
        .sclk        (sclk),
        .csel        (csel),
        .mosi        (mosi),
        .quad        (is_quad_dac),
        .frame_valid (frame_valid),
        .frame_data  (frame_data),
        .frame_cnt   (frame_cnt),
        .frame_err   (mon_err)
    );

    initial begin
        clkin = 1'b0;
        forever #50 clkin = ~clkin;  // 100 ns period
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);  // taps 16,14,13,11
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};  // one step per bit
            lfsr = lfsr_next(lfsr);
        end
        return r;
    endfunction

    // pad, cmd, channel, value; nop carries value zero
    function automatic logic [31:0] expect_word(input int ch, input logic sel,
                                                input logic [15:0] value);
        logic [3:0] cmd;
        cmd = sel ? 4'h3 : 4'h7;
        return {8'h00, cmd, 4'(ch), sel ? value : 16'h0000};
    endfunction

    task automatic end_with_failure();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check(input string name, input frame_t expected, input frame_t actual);
        if (actual !== expected) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            end_with_failure();
        end
    endtask

    task automatic push_expected(input string name, input dac_update_t u, input logic quad);
        logic [31:0] w [num_dac_ch];
        for (int c = 0; c < num_dac_ch; c++) begin
            w[c] = expect_word(c, u.ch_mask[c], u.value[c]);
        end
        if (quad) begin
            for (int c = 0; c < num_dac_ch; c++) begin
                exp_q.push_back(frame_t'(w[c][23:0]));  // pad byte goes out with csel high
                exp_name.push_back(name);
            end
        end else begin
            exp_q.push_back({w[0], w[1], w[2], w[3]});  // channel 0 shifted first
            exp_name.push_back(name);
        end
    endtask

    task automatic send_update(input string name, input logic quad, input logic full_mask);
        dac_update_t u;
        int          gap;
        gap = int'(take_bits(4));
        repeat (gap) @(negedge clkin);
        if (quad != is_quad_dac) begin
            while (!upd_ready) @(negedge clkin);  // mode changes only while idle
            is_quad_dac = quad;
        end
        u.ch_mask = full_mask ? 4'hf : 4'(take_bits(4));
        for (int c = 0; c < num_dac_ch; c++) begin
            u.value[c] = 16'(take_bits(16));
        end
        upd       = u;
        upd_valid = 1'b1;
        while (!upd_ready) @(negedge clkin);      // back-pressure, upd held
        push_expected(name, u, quad);             // taken on the next rising edge
        @(negedge clkin);
        upd_valid = 1'b0;
        upd       = ~u;                           // junk while not valid
    endtask

    task automatic run_phase(input string name, input int count, input int mode_sel,
                             input logic full_mask);
        logic quad;
        for (int i = 0; i < count; i++) begin
            case (mode_sel)
                mode_2601: quad = 1'b0;
                mode_quad: quad = 1'b1;
                default:   quad = 1'(take_bits(1));
            endcase
            send_update(name, quad, full_mask);
        end
    endtask

    // ready must stay low for the whole transfer
    always @(negedge clkin) begin
        if (!rst) begin
            check("ready_while_busy", frame_t'(1'b0), frame_t'(upd_ready && busy));
            check("busy_vs_csel", frame_t'(!csel), frame_t'(busy));  // busy while selected
        end
    end

    always @(posedge clkin) begin : frame_check
        frame_t exp_data;
        string  exp_tag;
        if (mon_err) begin
            $display("the bus monitor reported a framing error");
            end_with_failure();
        end else if (frame_valid) begin
            if (exp_q.size() == 0) begin
                $display("frame %0d arrived with no transfer expected", frame_cnt);
                end_with_failure();
            end else begin
                exp_data = exp_q.pop_front();
                exp_tag  = exp_name.pop_front();
                check($sformatf("%s frame %0d", exp_tag, frame_cnt), exp_data, frame_data);
            end
        end
    end

    initial begin
        repeat (timeout_cycles) @(posedge clkin);
        $display("timeout: transfers not finished within %0d clock cycles", timeout_cycles);
        end_with_failure();
    end

    initial begin
        rst         = 1'b1;
        upd_valid   = 1'b0;
        upd         = '0;
        is_quad_dac = 1'b0;
        repeat (16) @(negedge clkin);
        rst = 1'b0;
        check("reset_csel", frame_t'(1'b1), frame_t'(csel));
        check("reset_sclk", frame_t'(1'b0), frame_t'(sclk));
        check("reset_mosi", frame_t'(1'b0), frame_t'(mosi));
        check("reset_busy", frame_t'(1'b0), frame_t'(busy));
        check("reset_ready", frame_t'(1'b1), frame_t'(upd_ready));
        run_phase("full_mask_2601", phase_len, mode_2601, 1'b1);
        run_phase("part_mask_2601", phase_len, mode_2601, 1'b0);
        run_phase("quad", phase_len, mode_quad, 1'b0);
        run_phase("mode_switch", n_upd - 3 * phase_len, mode_mixed, 1'b0);
        while (exp_q.size() != 0) @(negedge clkin);
        repeat (drain_cycles) @(negedge clkin);  // a repeated transfer would show here
        check("ready_at_end", frame_t'(1'b1), frame_t'(upd_ready));
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* verilog/dac_top.sv */
`timescale 1ns/1ns
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DAC output top, controller, command memory and shifter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module dac_top
    import dac_pkg::*;
(
    input  logic        clkin,        // system clock
    input  logic        rst,          // sync reset, active high
    input  logic        upd_valid,    // host update offered
    input  dac_update_t upd,          // host mask and setpoints
    output logic        upd_ready,    // host update taken when valid
    input  logic        is_quad_dac,  // board type, static during a transfer
    output logic        sclk,         // DAC serial clock
    output logic        csel,         // DAC chip select, active low
    output logic        mosi,         // DAC serial data
    output logic        busy          // transfer in progress
);

    mem_wr_t               mem_wr;     // controller to memory
    logic [dac_addr_w-1:0] mem_addr;   // shifter read address
    logic                  mem_flush;  // shifter flush request
    dac_word_t             mem_word;   // word at mem_addr
    logic                  trig;
    logic                  xfer_done;

    dac_update_ctrl u_ctrl (
        .clkin     (clkin),
        .rst       (rst),
        .upd_valid (upd_valid),
        .upd       (upd),
        .upd_ready (upd_ready),
        .wr        (mem_wr),
        .trig      (trig),
        .xfer_done (xfer_done)
    );

    dac_cmd_mem u_mem (
        .clkin (clkin),
        .rst   (rst),
        .wr    (mem_wr),
        .addr  (mem_addr),
        .flush (mem_flush),
        .word  (mem_word)
    );

    dac_spi_shifter u_shift (
        .clkin       (clkin),
        .rst         (rst),
        .trig        (trig),
        .word        (mem_word),
        .addr        (mem_addr),
        .flush       (mem_flush),
        .is_quad_dac (is_quad_dac),
        .sclk        (sclk),
        .csel        (csel),
        .mosi        (mosi),
        .busy        (busy),
        .xfer_done   (xfer_done)
    );

endmodule

/* verilog/dac_update_ctrl.sv */
`timescale 1ns/1ns
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// setpoint update controller, memory writes and transfer trigger
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module dac_update_ctrl
    import dac_pkg::*;
(
    input  logic        clkin,      // system clock
    input  logic        rst,        // sync reset, active high
    input  logic        upd_valid,  // update offered
    input  dac_update_t upd,        // mask and setpoints
    output logic        upd_ready,  // update can be taken
    output mem_wr_t     wr,         // command memory write
    output logic        trig,       // one-cycle transfer start
    input  logic        xfer_done   // shifter finished the transfer
);

    typedef enum logic [1:0] {
        st_idle,
        st_write,
        st_trig,
        st_wait
    } ctrl_state_t;

    ctrl_state_t           state;
    logic [dac_addr_w-1:0] idx;     // channel being written
    dac_update_t           upd_q;   // accepted update
    logic                  accept;  // handshake this cycle

    assign upd_ready = (state == st_idle);  // low from accept to end of transfer
    assign accept    = upd_valid && upd_ready;
    assign trig      = (state == st_trig);

    // masked channels get a real setpoint, the others a nop so old values are not resent
    assign wr.wr_en   = (state == st_write);
    assign wr.wr_addr = idx;
    assign wr.wr_word = upd_q.ch_mask[idx] ?
                        make_word(cmd_write_update, idx, upd_q.value[idx]) :
                        nop_word(idx);

    always_ff @(posedge clkin) begin
        if (rst) begin
            state <= st_idle;
            idx   <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        state <= st_write;
                        idx   <= '0;        // address order 0 to 3
                    end
                end
                st_write: begin
                    idx <= idx + 1'b1;
                    if (idx == dac_addr_w'(num_dac_ch - 1)) begin
                        state <= st_trig;   // all entries written
                    end
                end
                st_trig: begin
                    state <= st_wait;       // trig seen by the idle shifter
                end
                st_wait: begin
                    if (xfer_done) begin
                        state <= st_idle;   // busy drops with this edge
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clkin) begin
        if (accept) begin
            upd_q <= upd;                   // held until the next accept
        end
    end

endmodule

/* vlog.f */
common/dac_pkg.sv
dac/dac_cmd_mem.sv
dac/dac_spi_shifter.sv
verilog/dac_update_ctrl.sv
verilog/dac_top.sv
sim/dac_spi_monitor.sv
sim/tb_dac_top.sv
